// File: verilog/qspi_cfg.svh
/*
 * Build constants for the parallel quad-IO configuration flash reader
 */
`ifndef QSPI_CFG_SVH
`define QSPI_CFG_SVH

// Devices sharing one chip select and one serial clock
`define QSPI_N_FLASH 4

// log2 of the device count
`define QSPI_LANE_SHIFT 2

// Controller byte address width
`define QSPI_ADDR_W 24

// Guard time in clocks before a session may start
`define QSPI_WAIT_CYCLES 32

// Dummy sck cycles after the address of a quad-IO read
`define QSPI_DUMMY_CYCLES 6

`endif

// File: verilog/qspi_cmd_pkg.sv
/*
 * Flash command set, status register layout and sequencer encodings
 */
package qspi_cmd_pkg;

	typedef logic [7:0] opcode_t;

	// Commands used by the reader
	localparam opcode_t OP_RDSR = 8'h05;
	localparam opcode_t OP_WREN = 8'h06;
	localparam opcode_t OP_WRSR = 8'h01;
	localparam opcode_t OP_QIOR = 8'hEB;

	// Status register layout
	localparam logic [7:0] SR_QE_VALUE = 8'h40;
	localparam int SR_QE_BIT = 6;
	localparam int SR_WIP_BIT = 0;

	typedef enum logic [3:0] {
		ST_INIT, ST_WAIT, ST_RDSR, ST_WREN, ST_WRSR, ST_POLL,
		ST_NCS_HIGH, ST_OPCODE, ST_ADDR, ST_DUMMY, ST_READ, ST_READ_HIGH
	} seq_state_e;

	// Item loaded into the serializer at the start of a phase
	typedef enum logic [1:0] {
		SEL_NONE, SEL_OPCODE, SEL_WRSR_DATA, SEL_ADDR
	} shift_sel_e;

endpackage

// File: verilog/qspi_bus_pkg.sv
/*
 * Controller side and pin side types of the configuration flash reader
 */
`include "qspi_cfg.svh"

package qspi_bus_pkg;

	typedef logic [`QSPI_ADDR_W-1:0] byte_addr_t;
	typedef logic [23:0] flash_addr_t;
	typedef logic [3:0] nibble_t;
	typedef logic [7:0] status_t;
	typedef logic [`QSPI_N_FLASH*4-1:0] data_word_t;
	typedef logic [`QSPI_N_FLASH-1:0] lane_mask_t;

	typedef struct packed {
		byte_addr_t addr;
		byte_addr_t stop_addr;
		logic addr_sload;
		logic addr_cnt_en;
		logic data_request;
		logic access_granted;
	} ctrl_req_t;

	typedef struct packed {
		logic data_ready;
		data_word_t data;
		logic done;
		logic access_request;
	} ctrl_rsp_t;

	// Shared by every device on the board
	typedef struct packed {
		logic sck;
		logic ncs;
		nibble_t io_out;
		logic [3:0] io_oe;
	} flash_out_t;

endpackage

// File: verilog/flash_lane.sv
/*
 * One device lane holding its status byte and its latest data nibble
 */
`timescale 1ns/1ps

module flash_lane (
	input  logic clk,
	input  logic nreset,
	input  qspi_bus_pkg::nibble_t io_in,
	input  logic capture_status,
	input  logic capture_data,
	output qspi_bus_pkg::status_t status,
	output qspi_bus_pkg::nibble_t nibble
);

	// Status arrives on io1 most significant bit first
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			status <= '0;
		else if (capture_status)
			status <= {status[6:0], io_in[1]};
	end

	// io3 lands in the top bit of the nibble
	always_ff @(posedge clk) begin
		if (capture_data)
			nibble <= io_in;
	end

endmodule

// File: verilog/lane_collector.sv
/*
 * Combines lane status into quad and idle flags and packs the data word
 */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module lane_collector (
	input  qspi_bus_pkg::status_t [`QSPI_N_FLASH-1:0] lane_status,
	input  qspi_bus_pkg::nibble_t [`QSPI_N_FLASH-1:0] lane_nibble,
	output logic all_quad,
	output logic all_idle,
	output qspi_bus_pkg::data_word_t data
);

	qspi_bus_pkg::lane_mask_t qe_mask;
	qspi_bus_pkg::lane_mask_t wip_mask;

	always_comb begin
		for (int k = 0; k < `QSPI_N_FLASH; k++) begin
			qe_mask[k] = lane_status[k][qspi_cmd_pkg::SR_QE_BIT];
			wip_mask[k] = lane_status[k][qspi_cmd_pkg::SR_WIP_BIT];
			// Device k owns nibble k of the word
			data[4*k +: 4] = lane_nibble[k];
		end
	end

	// Every device must agree before the read may start
	assign all_quad = &qe_mask;
	assign all_idle = ~|wip_mask;

endmodule

// File: verilog/qspi_shifter.sv
/*
 * Serializer for opcodes, status value and address on the shared IO lines
 */
`timescale 1ns/1ps

module qspi_shifter (
	input  logic clk,
	input  logic nreset,
	input  qspi_cmd_pkg::seq_state_e state,
	input  qspi_cmd_pkg::shift_sel_e shift_sel,
	input  logic shift_load,
	input  logic sck_rise,
	input  qspi_bus_pkg::flash_addr_t flash_addr,
	output qspi_bus_pkg::nibble_t pins_io,
	output logic [3:0] pins_oe
);

	qspi_cmd_pkg::opcode_t opcode;
	logic [23:0] load_value;
	logic [23:0] sreg;
	logic [23:0] cur;

	always_comb begin
		case (state)
			qspi_cmd_pkg::ST_RDSR, qspi_cmd_pkg::ST_POLL: opcode = qspi_cmd_pkg::OP_RDSR;
			qspi_cmd_pkg::ST_WREN: opcode = qspi_cmd_pkg::OP_WREN;
			default: opcode = qspi_cmd_pkg::OP_QIOR;
		endcase
		case (shift_sel)
			qspi_cmd_pkg::SEL_OPCODE: load_value = {opcode, 16'h0000};
			qspi_cmd_pkg::SEL_WRSR_DATA:
				load_value = {qspi_cmd_pkg::OP_WRSR, qspi_cmd_pkg::SR_QE_VALUE, 8'h00};
			qspi_cmd_pkg::SEL_ADDR: load_value = flash_addr;
			default: load_value = '0;
		endcase
	end

	// First bit is visible during the load cycle so it is stable at the first rise
	assign cur = shift_load ? load_value : sreg;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			sreg <= '0;
		else if (shift_load)
			sreg <= load_value;
		else if (sck_rise) begin
			if (state == qspi_cmd_pkg::ST_ADDR)
				sreg <= {sreg[19:0], 4'h0};
			else
				sreg <= {sreg[22:0], 1'b0};
		end
	end

	// Line levels per phase, io1 is left free for status readback
	always_comb begin
		case (state)
			qspi_cmd_pkg::ST_ADDR: begin
				pins_io = cur[23:20];
				pins_oe = 4'b1111;
			end
			qspi_cmd_pkg::ST_DUMMY: begin
				pins_io = 4'b0000;
				pins_oe = 4'b1111;
			end
			qspi_cmd_pkg::ST_READ, qspi_cmd_pkg::ST_READ_HIGH: begin
				pins_io = 4'b0000;
				pins_oe = 4'b0000;
			end
			default: begin
				pins_io = {2'b11, 1'b0, cur[23]};
				pins_oe = 4'b1101;
			end
		endcase
	end

endmodule

// File: verilog/qspi_sequencer.sv
/*
 * Session FSM of the flash reader with status checks, pacing counters,
 * controller handshakes and the word counter behind the done flag
 */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module qspi_sequencer (
	input  logic clk,
	input  logic nreset,
	input  qspi_bus_pkg::ctrl_req_t ctrl,
	input  logic all_quad,
	input  logic all_idle,
	output qspi_cmd_pkg::seq_state_e state,
	output qspi_cmd_pkg::shift_sel_e shift_sel,
	output logic shift_load,
	output logic sck_rise,
	output logic sck,
	output logic ncs,
	output logic capture_status,
	output logic capture_data,
	output qspi_bus_pkg::flash_addr_t flash_addr,
	output logic data_ready,
	output logic done,
	output logic access_request
);

	localparam int WORD_SHIFT = `QSPI_LANE_SHIFT - 1;
	localparam int NCS_HIGH_CYCLES = 16;

	qspi_cmd_pkg::seq_state_e next_state;
	qspi_cmd_pkg::seq_state_e last_cmd;
	logic [4:0] bit_cnt;
	logic [5:0] tmr;
	logic pending;
	logic granted;
	logic cmd_phase;
	logic last_bit;
	logic abort;
	logic advance;
	qspi_bus_pkg::byte_addr_t word_cnt;
	qspi_bus_pkg::byte_addr_t stop_word;

	function automatic logic is_cmd(input qspi_cmd_pkg::seq_state_e s);
		return s inside {qspi_cmd_pkg::ST_RDSR, qspi_cmd_pkg::ST_WREN,
			qspi_cmd_pkg::ST_WRSR, qspi_cmd_pkg::ST_POLL, qspi_cmd_pkg::ST_OPCODE,
			qspi_cmd_pkg::ST_ADDR, qspi_cmd_pkg::ST_DUMMY};
	endfunction

	// Number of sck rises in each command phase
	function automatic logic [4:0] cmd_bits(input qspi_cmd_pkg::seq_state_e s);
		case (s)
			qspi_cmd_pkg::ST_WREN, qspi_cmd_pkg::ST_OPCODE: cmd_bits = 5'd8;
			qspi_cmd_pkg::ST_ADDR: cmd_bits = 5'd6;
			qspi_cmd_pkg::ST_DUMMY: cmd_bits = 5'(`QSPI_DUMMY_CYCLES);
			default: cmd_bits = 5'd16;
		endcase
	endfunction

	// sck_rise marks the high half of sck, the bit is consumed at its end
	assign cmd_phase = is_cmd(state);
	assign sck_rise = cmd_phase && sck;
	assign last_bit = sck_rise && (bit_cnt == cmd_bits(state) - 5'd1);
	assign shift_load = cmd_phase && !sck && (bit_cnt == 5'd0);

	assign data_ready = (state == qspi_cmd_pkg::ST_READ_HIGH);
	assign capture_data = (state == qspi_cmd_pkg::ST_READ);
	assign capture_status = sck_rise && (bit_cnt >= 5'd8) &&
		(state == qspi_cmd_pkg::ST_RDSR || state == qspi_cmd_pkg::ST_POLL);

	assign abort = pending || !granted;
	assign advance = data_ready && ctrl.addr_cnt_en && !abort;

	always_comb begin
		case (state)
			qspi_cmd_pkg::ST_RDSR, qspi_cmd_pkg::ST_WREN,
			qspi_cmd_pkg::ST_POLL, qspi_cmd_pkg::ST_OPCODE: shift_sel = qspi_cmd_pkg::SEL_OPCODE;
			qspi_cmd_pkg::ST_WRSR: shift_sel = qspi_cmd_pkg::SEL_WRSR_DATA;
			qspi_cmd_pkg::ST_ADDR: shift_sel = qspi_cmd_pkg::SEL_ADDR;
			default: shift_sel = qspi_cmd_pkg::SEL_NONE;
		endcase
	end

	// ********************
	// Next state
	// ********************
	always_comb begin
		next_state = state;
		case (state)
			qspi_cmd_pkg::ST_INIT: next_state = qspi_cmd_pkg::ST_WAIT;
			qspi_cmd_pkg::ST_WAIT: begin
				if (tmr == 6'(`QSPI_WAIT_CYCLES) && pending && granted && ctrl.data_request)
					next_state = qspi_cmd_pkg::ST_RDSR;
			end
			qspi_cmd_pkg::ST_RDSR, qspi_cmd_pkg::ST_WREN,
			qspi_cmd_pkg::ST_WRSR, qspi_cmd_pkg::ST_POLL: begin
				if (last_bit)
					next_state = qspi_cmd_pkg::ST_NCS_HIGH;
			end
			qspi_cmd_pkg::ST_OPCODE: begin
				if (last_bit)
					next_state = qspi_cmd_pkg::ST_ADDR;
			end
			qspi_cmd_pkg::ST_ADDR: begin
				if (last_bit)
					next_state = qspi_cmd_pkg::ST_DUMMY;
			end
			qspi_cmd_pkg::ST_DUMMY: begin
				if (last_bit)
					next_state = qspi_cmd_pkg::ST_READ;
			end
			qspi_cmd_pkg::ST_READ: begin
				next_state = abort ? qspi_cmd_pkg::ST_WAIT : qspi_cmd_pkg::ST_READ_HIGH;
			end
			qspi_cmd_pkg::ST_READ_HIGH: begin
				if (abort)
					next_state = qspi_cmd_pkg::ST_WAIT;
				else if (ctrl.addr_cnt_en)
					next_state = qspi_cmd_pkg::ST_READ;
			end
			qspi_cmd_pkg::ST_NCS_HIGH: begin
				// Branch on the command that just finished
				if (tmr == 6'(NCS_HIGH_CYCLES - 1)) begin
					case (last_cmd)
						qspi_cmd_pkg::ST_RDSR: next_state = all_quad ?
							qspi_cmd_pkg::ST_OPCODE : qspi_cmd_pkg::ST_WREN;
						qspi_cmd_pkg::ST_WREN: next_state = qspi_cmd_pkg::ST_WRSR;
						qspi_cmd_pkg::ST_WRSR: next_state = qspi_cmd_pkg::ST_POLL;
						default: next_state = all_idle ?
							qspi_cmd_pkg::ST_RDSR : qspi_cmd_pkg::ST_POLL;
					endcase
				end
			end
			default: next_state = qspi_cmd_pkg::ST_INIT;
		endcase
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			state <= qspi_cmd_pkg::ST_INIT;
			last_cmd <= qspi_cmd_pkg::ST_RDSR;
			sck <= 1'b0;
			ncs <= 1'b1;
			bit_cnt <= '0;
			tmr <= '0;
		end else begin
			state <= next_state;
			// Half rate sck in command phases, held high while a word waits
			sck <= (next_state == qspi_cmd_pkg::ST_READ_HIGH) ||
				(cmd_phase && is_cmd(next_state) && !sck);
			ncs <= !(is_cmd(next_state) || next_state == qspi_cmd_pkg::ST_READ ||
				next_state == qspi_cmd_pkg::ST_READ_HIGH);
			if (cmd_phase)
				last_cmd <= state;
			if (next_state != state) begin
				bit_cnt <= '0;
				tmr <= '0;
			end else begin
				if (sck_rise)
					bit_cnt <= bit_cnt + 5'd1;
				if (tmr != 6'(`QSPI_WAIT_CYCLES))
					tmr <= tmr + 6'd1;
			end
		end
	end

	// ********************
	// Controller side
	// ********************
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			access_request <= 1'b0;
			granted <= 1'b0;
			pending <= 1'b0;
			word_cnt <= '0;
			done <= 1'b0;
		end else begin
			access_request <= ctrl.data_request;
			if (!ctrl.data_request)
				granted <= 1'b0;
			else if (!granted)
				granted <= ctrl.access_granted;
			// A load stays pending until its address goes out
			if (ctrl.addr_sload)
				pending <= 1'b1;
			else if (state == qspi_cmd_pkg::ST_OPCODE && last_bit)
				pending <= 1'b0;
			if (ctrl.addr_sload)
				word_cnt <= ctrl.addr >> WORD_SHIFT;
			else if (advance)
				word_cnt <= word_cnt + 1'b1;
			if (ctrl.addr_sload)
				done <= 1'b0;
			else if (word_cnt == stop_word)
				done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.addr_sload) begin
			flash_addr <= qspi_bus_pkg::flash_addr_t'(ctrl.addr >> `QSPI_LANE_SHIFT);
			stop_word <= ctrl.stop_addr >> WORD_SHIFT;
		end
	end

endmodule

// File: verilog/qspi_cfg_flash.sv
/*
 * Configuration flash reader for parallel quad-IO serial flash devices
 */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module qspi_cfg_flash (
	input  logic clk,
	input  logic nreset,
	input  qspi_bus_pkg::ctrl_req_t ctrl,
	output qspi_bus_pkg::ctrl_rsp_t rsp,
	output qspi_bus_pkg::flash_out_t flash_out,
	input  qspi_bus_pkg::nibble_t [`QSPI_N_FLASH-1:0] flash_io_in
);

	qspi_cmd_pkg::seq_state_e state;
	qspi_cmd_pkg::shift_sel_e shift_sel;
	qspi_bus_pkg::flash_addr_t flash_addr;
	qspi_bus_pkg::nibble_t pins_io;
	qspi_bus_pkg::status_t [`QSPI_N_FLASH-1:0] lane_status;
	qspi_bus_pkg::nibble_t [`QSPI_N_FLASH-1:0] lane_nibble;
	qspi_bus_pkg::data_word_t data;
	logic [3:0] pins_oe;
	logic shift_load;
	logic sck_rise;
	logic sck;
	logic ncs;
	logic capture_status;
	logic capture_data;
	logic all_quad;
	logic all_idle;
	logic data_ready;
	logic done;
	logic access_request;

	qspi_sequencer u_sequencer (
		.clk(clk),
		.nreset(nreset),
		.ctrl(ctrl),
		.all_quad(all_quad),
		.all_idle(all_idle),
		.state(state),
		.shift_sel(shift_sel),
		.shift_load(shift_load),
		.sck_rise(sck_rise),
		.sck(sck),
		.ncs(ncs),
		.capture_status(capture_status),
		.capture_data(capture_data),
		.flash_addr(flash_addr),
		.data_ready(data_ready),
		.done(done),
		.access_request(access_request)
	);

	qspi_shifter u_shifter (
		.clk(clk),
		.nreset(nreset),
		.state(state),
		.shift_sel(shift_sel),
		.shift_load(shift_load),
		.sck_rise(sck_rise),
		.flash_addr(flash_addr),
		.pins_io(pins_io),
		.pins_oe(pins_oe)
	);

	// One lane per device
	for (genvar k = 0; k < `QSPI_N_FLASH; k++) begin : g_lane
		flash_lane u_lane (
			.clk(clk),
			.nreset(nreset),
			.io_in(flash_io_in[k]),
			.capture_status(capture_status),
			.capture_data(capture_data),
			.status(lane_status[k]),
			.nibble(lane_nibble[k])
		);
	end

	lane_collector u_collector (
		.lane_status(lane_status),
		.lane_nibble(lane_nibble),
		.all_quad(all_quad),
		.all_idle(all_idle),
		.data(data)
	);

	assign rsp = '{data_ready: data_ready, data: data, done: done,
		access_request: access_request};
	assign flash_out = '{sck: sck, ncs: ncs, io_out: pins_io, io_oe: pins_oe};

endmodule

// File: sim/qspi_flash_model.sv
/*
 * Behavioral model of the parallel quad-IO flash devices on one chip select
 */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module qspi_flash_model (
	input  logic clk,
	input  logic nreset,
	input  qspi_bus_pkg::lane_mask_t qe_init,
	input  qspi_bus_pkg::flash_out_t flash_out,
	output qspi_bus_pkg::nibble_t [`QSPI_N_FLASH-1:0] flash_io_in,
	output int wren_count,
	output int wrsr_count
);

	// Rises before the first data nibble of a quad-IO read
	localparam int DATA_RISE = 8 + 6 + `QSPI_DUMMY_CYCLES;

	qspi_bus_pkg::lane_mask_t qe;
	qspi_bus_pkg::flash_addr_t addr;
	qspi_cmd_pkg::opcode_t opcode;
	logic [7:0] in_byte;
	logic [7:0] wr_value;
	logic prev_sck;
	logic prev_ncs;
	logic wel;
	logic sck_rose;
	int rise_cnt;
	int busy_polls;

	function automatic logic [7:0] stored_byte(input int a, input int k);
		return 8'((a * 7 + k * 29) % 256);
	endfunction

	// sck is sampled on the clock so a rise is seen in its first high cycle
	assign sck_rose = flash_out.sck && !prev_sck;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			qe <= qe_init;
			addr <= '0;
			opcode <= '0;
			in_byte <= '0;
			wr_value <= '0;
			prev_sck <= 1'b0;
			prev_ncs <= 1'b1;
			wel <= 1'b0;
			rise_cnt <= 0;
			busy_polls <= 0;
			wren_count <= 0;
			wrsr_count <= 0;
		end else begin
			prev_sck <= flash_out.sck;
			prev_ncs <= flash_out.ncs;
			if (flash_out.ncs) begin
				rise_cnt <= 0;
				opcode <= '0;
				// Commands take effect when chip select rises
				if (!prev_ncs) begin
					case (opcode)
						qspi_cmd_pkg::OP_WREN: begin
							wel <= 1'b1;
							wren_count <= wren_count + 1;
						end
						qspi_cmd_pkg::OP_WRSR: begin
							if (wel && rise_cnt >= 16) begin
								qe <= {`QSPI_N_FLASH{wr_value[qspi_cmd_pkg::SR_QE_BIT]}};
								busy_polls <= 3;
								wel <= 1'b0;
								wrsr_count <= wrsr_count + 1;
							end
						end
						qspi_cmd_pkg::OP_RDSR: begin
							if (rise_cnt >= 16 && busy_polls != 0)
								busy_polls <= busy_polls - 1;
						end
						default: ;
					endcase
				end
			end else if (sck_rose) begin
				rise_cnt <= rise_cnt + 1;
				if (rise_cnt < 8)
					in_byte <= {in_byte[6:0], flash_out.io_out[0]};
				if (rise_cnt == 7)
					opcode <= {in_byte[6:0], flash_out.io_out[0]};
				if (opcode == qspi_cmd_pkg::OP_QIOR && rise_cnt >= 8 && rise_cnt < 14)
					addr <= {addr[19:0], flash_out.io_out};
				if (opcode == qspi_cmd_pkg::OP_WRSR && rise_cnt >= 8 && rise_cnt < 16)
					wr_value <= {wr_value[6:0], flash_out.io_out[0]};
			end
		end
	end

	// Status on io1 and data nibbles, changed only while sck is low
	always_comb begin
		logic [7:0] status_k;
		logic [7:0] b;
		int nib_idx;
		flash_io_in = '0;
		for (int k = 0; k < `QSPI_N_FLASH; k++) begin
			status_k = {1'b0, qe[k], 5'b00000, busy_polls != 0};
			nib_idx = rise_cnt - DATA_RISE;
			b = stored_byte(int'(addr) + nib_idx / 2, k);
			if (!flash_out.ncs && opcode == qspi_cmd_pkg::OP_RDSR &&
				rise_cnt >= 8 && rise_cnt < 16)
				flash_io_in[k][1] = status_k[15 - rise_cnt];
			else if (!flash_out.ncs && opcode == qspi_cmd_pkg::OP_QIOR && nib_idx >= 0)
				flash_io_in[k] = nib_idx[0] ? b[3:0] : b[7:4];
		end
	end

endmodule

// File: sim/qspi_cfg_checker.sv
/*
 * Pin and handshake assertions for the configuration flash reader
 */
`timescale 1ns/1ps

module qspi_cfg_checker (
	input  logic clk,
	input  logic nreset,
	input  logic sck,
	input  logic ncs,
	input  logic data_ready,
	input  logic access_request,
	input  logic data_request
);

	// Failures seen so far, read by the testbench at the end
	int assert_fails = 0;

	sck_low_while_deselected: assert property (@(posedge clk) disable iff (!nreset)
		ncs |-> !sck)
		else begin
			assert_fails++;
			$error("sck is high while ncs is high");
		end

	ready_only_when_selected: assert property (@(posedge clk) disable iff (!nreset)
		data_ready |-> !ncs)
		else begin
			assert_fails++;
			$error("data_ready is high while ncs is high");
		end

	request_follows_controller: assert property (@(posedge clk) disable iff (!nreset)
		access_request == $past(data_request))
		else begin
			assert_fails++;
			$error("access_request does not follow data_request by one clock");
		end

endmodule

bind qspi_cfg_flash qspi_cfg_checker u_checker (
	.clk(clk),
	.nreset(nreset),
	.sck(sck),
	.ncs(ncs),
	.data_ready(data_ready),
	.access_request(access_request),
	.data_request(ctrl.data_request)
);

// File: sim/tb_qspi_cfg_flash.sv
/*
 * Directed testbench of the configuration flash reader against a flash model
 */
`timescale 1ns/1ps
`include "qspi_cfg.svh"

module tb_qspi_cfg_flash;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	// Longest session with the quad enable write and back-pressure stays under this
	localparam int SESSION_CYCLES = 2500;
	// Six sessions plus resets and margin
	localparam int TIMEOUT_CYCLES = 8 * SESSION_CYCLES;

	logic clk;
	logic nreset;
	qspi_bus_pkg::ctrl_req_t ctrl;
	qspi_bus_pkg::ctrl_rsp_t rsp;
	qspi_bus_pkg::flash_out_t flash_out;
	qspi_bus_pkg::nibble_t [`QSPI_N_FLASH-1:0] flash_io_in;
	qspi_bus_pkg::lane_mask_t qe_init;
	int wren_count;
	int wrsr_count;
	int cycles = 0;
	int word_errors = 0;
	int bit_errors = 0;
	int oe_errors = 0;
	int count_errors = 0;
	int assert_errors;
	string waiting_for = "reset";

	qspi_cfg_flash u_qspi_cfg_flash (
		.clk(clk),
		.nreset(nreset),
		.ctrl(ctrl),
		.rsp(rsp),
		.flash_out(flash_out),
		.flash_io_in(flash_io_in)
	);

	qspi_flash_model u_flash_model (
		.clk(clk),
		.nreset(nreset),
		.qe_init(qe_init),
		.flash_out(flash_out),
		.flash_io_in(flash_io_in),
		.wren_count(wren_count),
		.wrsr_count(wrsr_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles while waiting for %s", cycles, waiting_for);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ********************
	// Compare tasks
	// ********************
	task automatic check_word(input string name, input qspi_bus_pkg::data_word_t got,
		input qspi_bus_pkg::data_word_t exp);
		if (got !== exp) begin
			word_errors++;
			$display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			bit_errors++;
			$display("ERR %0t %s: expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_oe(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			oe_errors++;
			$display("ERR %0t %s: expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			count_errors++;
			$display("ERR %0t %s: expected %0d, got %0d", $time, name, exp, got);
		end
	endtask

	// Word j carries nibble j of each device with the high nibble of a byte first
	function automatic qspi_bus_pkg::data_word_t expected_word(
		input qspi_bus_pkg::byte_addr_t start, input int j);
		qspi_bus_pkg::data_word_t w;
		logic [7:0] b;
		int dev_addr;
		dev_addr = int'(start >> `QSPI_LANE_SHIFT) + j / 2;
		for (int k = 0; k < `QSPI_N_FLASH; k++) begin
			b = 8'((dev_addr * 7 + k * 29) % 256);
			w[4*k +: 4] = (j % 2 == 0) ? b[7:4] : b[3:0];
		end
		return w;
	endfunction

	// ********************
	// Stimulus helpers
	// ********************
	task automatic apply_reset(input qspi_bus_pkg::lane_mask_t mask);
		@(posedge clk);
		nreset <= 1'b0;
		ctrl <= '0;
		qe_init <= mask;
		repeat (RESET_CYCLES) @(posedge clk);
		nreset <= 1'b1;
	endtask

	task automatic start_session(input qspi_bus_pkg::byte_addr_t start,
		input qspi_bus_pkg::byte_addr_t stop);
		@(posedge clk);
		ctrl.addr <= start;
		ctrl.stop_addr <= stop;
		ctrl.addr_sload <= 1'b1;
		ctrl.data_request <= 1'b1;
		@(posedge clk);
		ctrl.addr_sload <= 1'b0;
		waiting_for = "access_request";
		@(negedge clk);
		while (!rsp.access_request)
			@(negedge clk);
		@(posedge clk);
		ctrl.access_granted <= 1'b1;
	endtask

	// Takes count words and holds each back for up to max_gap cycles
	task automatic stream_words(input qspi_bus_pkg::byte_addr_t start, input int count,
		input int done_at, input int max_gap);
		qspi_bus_pkg::data_word_t held;
		int gap;
		for (int j = 0; j < count; j++) begin
			waiting_for = "data_ready";
			@(negedge clk);
			while (!rsp.data_ready)
				@(negedge clk);
			check_word("data", rsp.data, expected_word(start, j));
			check_bit("done", rsp.done, j >= done_at);
			// All lines are released while words are read
			check_oe("io_oe", flash_out.io_oe, 4'b0000);
			held = rsp.data;
			gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
			repeat (gap) begin
				@(negedge clk);
				check_bit("data_ready", rsp.data_ready, 1'b1);
				check_word("data", rsp.data, held);
			end
			@(posedge clk);
			ctrl.addr_cnt_en <= 1'b1;
			@(posedge clk);
			ctrl.addr_cnt_en <= 1'b0;
		end
	endtask

	task automatic end_session();
		@(posedge clk);
		ctrl.data_request <= 1'b0;
		ctrl.access_granted <= 1'b0;
		waiting_for = "ncs release";
		@(negedge clk);
		while (!flash_out.ncs)
			@(negedge clk);
	endtask

	// ********************
	// Directed tests
	// ********************
	task automatic reset_values();
		apply_reset('1);
		@(negedge clk);
		check_bit("ncs", flash_out.ncs, 1'b1);
		check_bit("sck", flash_out.sck, 1'b0);
		check_bit("data_ready", rsp.data_ready, 1'b0);
		check_bit("done", rsp.done, 1'b0);
		check_bit("access_request", rsp.access_request, 1'b0);
	endtask

	task automatic stream_quad_set();
		apply_reset('1);
		start_session(24'h000100, 24'h000100 + 24'd32);
		stream_words(24'h000100, 16, 16, 0);
		end_session();
		check_count("wren_count", wren_count, 0);
		check_count("wrsr_count", wrsr_count, 0);
	endtask

	// Device 2 starts without quad mode
	task automatic enable_quad_then_stream();
		apply_reset(4'b1011);
		start_session(24'h0002a0, 24'h0002a0 + 24'd32);
		stream_words(24'h0002a0, 16, 16, 0);
		end_session();
		check_count("wren_count", wren_count, 1);
		check_count("wrsr_count", wrsr_count, 1);
	endtask

	// Expected data per index also shows that no word is skipped
	task automatic stream_with_backpressure();
		apply_reset('1);
		start_session(24'h000040, 24'h000040 + 24'd64);
		stream_words(24'h000040, 16, 32, 7);
		end_session();
	endtask

	task automatic done_at_stop();
		apply_reset('1);
		start_session(24'h000080, 24'h000080 + 24'd20);
		stream_words(24'h000080, 14, 10, 2);
		end_session();
	endtask

	task automatic regrant_and_reload();
		apply_reset('1);
		start_session(24'h000400, 24'h000400 + 24'd128);
		stream_words(24'h000400, 5, 64, 0);
		@(posedge clk);
		ctrl.data_request <= 1'b0;
		ctrl.access_granted <= 1'b0;
		repeat (4) @(negedge clk);
		check_bit("ncs", flash_out.ncs, 1'b1);
		check_bit("data_ready", rsp.data_ready, 1'b0);
		start_session(24'h000800, 24'h000800 + 24'd128);
		stream_words(24'h000800, 8, 64, 0);
		end_session();
	endtask

	initial begin
		nreset = 1'b0;
		ctrl = '0;
		qe_init = '1;
		void'($urandom(63));
		reset_values();
		stream_quad_set();
		enable_quad_then_stream();
		stream_with_backpressure();
		done_at_stop();
		regrant_and_reload();
		repeat (4) @(posedge clk);
		assert_errors = u_qspi_cfg_flash.u_checker.assert_fails;
		$display("Errors: word %0d, bit %0d, oe %0d, count %0d, assertion %0d",
			word_errors, bit_errors, oe_errors, count_errors, assert_errors);
		if (word_errors + bit_errors + oe_errors + count_errors + assert_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+verilog
verilog/qspi_cmd_pkg.sv
verilog/qspi_bus_pkg.sv
verilog/flash_lane.sv
verilog/lane_collector.sv
verilog/qspi_shifter.sv
verilog/qspi_sequencer.sv
verilog/qspi_cfg_flash.sv
sim/qspi_flash_model.sv
sim/qspi_cfg_checker.sv
sim/tb_qspi_cfg_flash.sv
